//--- common/pkg_rf.sv
package pkg_rf;

	////////////////////
	// Array sizes
	localparam int IDX_W	= 5;				// Register index width
	localparam int DATA_W	= 32;				// Operand width
	localparam int NUM_REGS	= 32;				// Entries in the array

	////////////////////
	// Basic types
	typedef logic [IDX_W-1:0]	idx_t;			// Register index
	typedef logic [DATA_W-1:0]	data_t;			// Register word
	typedef logic [2:0]			route_t;		// {odd3, odd2, odd1}

	////////////////////
	// Pass kind, seen by steering one cycle after the read
	localparam logic [1:0] PK_NONE		= 2'd0;	// Nothing read
	localparam logic [1:0] PK_FULL		= 2'd1;	// All three sources at once
	localparam logic [1:0] PK_FIRST		= 2'd2;	// Sources 1 and 2 of a split
	localparam logic [1:0] PK_SECOND	= 2'd3;	// Source 3 of a split, on port 1

	// Control state
	typedef enum logic {
		FS_IDLE,								// Single pass or no work
		FS_SPLIT								// Second pass for source 3
	} fetch_state_t;

endpackage

//--- src/rf_index_sel.sv
`timescale 1ns/100ps

module rf_index_sel
	import pkg_rf::*;
(
	input	logic		odd1,					// Odd flag of source 1
	input	logic		odd2,					// Odd flag of source 2
	input	logic		odd3,					// Odd flag of source 3
	input	idx_t		idx_src1,				// Source 1 index
	input	idx_t		idx_src2,				// Source 2 index
	input	idx_t		idx_src3,				// Source 3 index
	output	idx_t		port_idx1,				// Read port 1 address
	output	idx_t		port_idx2,				// Read port 2 address
	output	idx_t		port_idx3,				// Read port 3 address
	output	idx_t		port_idx4				// Read port 4 address
);

	route_t		sel;

	assign sel = {odd3, odd2, odd1};

	// Fixed port table; unused ports read entry 0
	always_comb begin
		case (sel)
			3'd0: begin								// No slot for s3 so a split
				port_idx1 = idx_src1;
				port_idx2 = idx_src2;
				port_idx3 = '0;
				port_idx4 = '0;
			end
			3'd1: begin
				port_idx1 = idx_src1;
				port_idx2 = idx_src2;
				port_idx3 = idx_src3;
				port_idx4 = '0;
			end
			3'd2: begin
				port_idx1 = idx_src1;
				port_idx2 = idx_src3;
				port_idx3 = idx_src2;
				port_idx4 = '0;
			end
			3'd3: begin
				port_idx1 = idx_src1;
				port_idx2 = '0;
				port_idx3 = idx_src2;
				port_idx4 = idx_src3;
			end
			3'd4: begin
				port_idx1 = idx_src3;
				port_idx2 = idx_src2;
				port_idx3 = idx_src1;
				port_idx4 = '0;
			end
			3'd5: begin
				port_idx1 = '0;
				port_idx2 = idx_src2;
				port_idx3 = idx_src1;
				port_idx4 = idx_src3;
			end
			3'd6: begin
				port_idx1 = '0;
				port_idx2 = idx_src3;
				port_idx3 = idx_src1;
				port_idx4 = idx_src2;
			end
			default: begin							// Code 7 needs a split too
				port_idx1 = '0;
				port_idx2 = '0;
				port_idx3 = idx_src1;
				port_idx4 = idx_src2;
			end
		endcase
	end

endmodule

//--- register_file/rf_array.sv
`timescale 1ns/100ps

module rf_array
	import pkg_rf::*;
(
	input	logic		clk,
	input	logic		arst_n,
	input	logic		wr_en,					// Write strobe
	input	idx_t		wr_idx,					// Write address
	input	data_t		wr_data,				// Write word
	input	idx_t		port_idx1,
	input	idx_t		port_idx2,
	input	idx_t		port_idx3,
	input	idx_t		port_idx4,
	output	data_t		port_data1,				// Valid one cycle after address
	output	data_t		port_data2,
	output	data_t		port_data3,
	output	data_t		port_data4
);

	data_t		mem [NUM_REGS];

	////////////////////
	// Storage, one write port
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				mem[i] <= '0;						// All entries read zero
			end
		end else if (wr_en) begin
			mem[wr_idx] <= wr_data;
		end
	end

	////////////////////
	// Registered read ports
	// Same-edge write is not visible yet, old word comes out
	always_ff @(posedge clk) begin
		port_data1 <= mem[port_idx1];
		port_data2 <= mem[port_idx2];
		port_data3 <= mem[port_idx3];
		port_data4 <= mem[port_idx4];
	end

endmodule

//--- src/rf_read_steer.sv
`timescale 1ns/100ps

module rf_read_steer
	import pkg_rf::*;
(
	input	logic		clk,
	input	logic		arst_n,
	input	logic [1:0]	pass_kind,				// Pass that produced port_data
	input	route_t		route,					// Route code of that pass
	input	data_t		port_data1,
	input	data_t		port_data2,
	input	data_t		port_data3,
	input	data_t		port_data4,
	output	data_t		op1,					// Operand registers
	output	data_t		op2,
	output	data_t		op3
);

	data_t		src_d1;							// Source 1 word, unrouted
	data_t		src_d2;
	data_t		src_d3;

	////////////////////
	// Inverse of the index table
	always_comb begin
		case (route)
			3'd0: begin
				src_d1 = port_data1;
				src_d2 = port_data2;
				src_d3 = '0;						// Comes in the second pass
			end
			3'd1: begin
				src_d1 = port_data1;
				src_d2 = port_data2;
				src_d3 = port_data3;
			end
			3'd2: begin
				src_d1 = port_data1;
				src_d2 = port_data3;
				src_d3 = port_data2;
			end
			3'd3: begin
				src_d1 = port_data1;
				src_d2 = port_data3;
				src_d3 = port_data4;
			end
			3'd4: begin
				src_d1 = port_data3;
				src_d2 = port_data2;
				src_d3 = port_data1;
			end
			3'd5: begin
				src_d1 = port_data3;
				src_d2 = port_data2;
				src_d3 = port_data4;
			end
			3'd6: begin
				src_d1 = port_data3;
				src_d2 = port_data4;
				src_d3 = port_data2;
			end
			default: begin
				src_d1 = port_data3;
				src_d2 = port_data4;
				src_d3 = '0;						// Code 7 split as well
			end
		endcase
	end

	////////////////////
	// Operand load by pass kind
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			op1 <= '0;
			op2 <= '0;
			op3 <= '0;
		end else begin
			case (pass_kind)
				PK_FULL: begin
					op1 <= src_d1;
					op2 <= src_d2;
					op3 <= src_d3;
				end
				PK_FIRST: begin					// op3 waits for next pass
					op1 <= src_d1;
					op2 <= src_d2;
				end
				PK_SECOND: begin
					op3 <= port_data1;				// s3 alone on port 1
				end
				default: ;							// Hold until next valid
			endcase
		end
	end

endmodule

//--- src/fetch_ctrl.sv
`timescale 1ns/100ps

module fetch_ctrl
	import pkg_rf::*;
(
	input	logic		clk,
	input	logic		arst_n,
	input	logic		issue,					// One-cycle issue strobe
	input	logic		odd1,
	input	logic		odd2,
	input	logic		odd3,
	input	idx_t		src1_idx,
	input	idx_t		src2_idx,
	input	idx_t		src3_idx,
	output	logic		sel_odd1,				// Flags to index select
	output	logic		sel_odd2,
	output	logic		sel_odd3,
	output	idx_t		sel_idx1,				// Indices to index select
	output	idx_t		sel_idx2,
	output	idx_t		sel_idx3,
	output	route_t		route,					// Delayed, lines up with data
	output	logic [1:0]	pass_kind,				// Delayed, lines up with data
	output	logic		busy,					// Second pass in progress
	output	logic		op_valid				// Operands complete
);

	fetch_state_t	state;
	idx_t			src3_hold;					// s3 kept for the second pass
	logic			accept;
	logic			split;
	logic [1:0]		pass_now;					// Pass kind of this cycle's read

	assign accept	= issue && (state == FS_IDLE);
	assign split	= (odd1 == odd2) && (odd2 == odd3);	// Codes 0 and 7
	assign busy		= (state == FS_SPLIT);

	// Forward to index select; second pass is s3 in slot 1, code 0
	always_comb begin
		if (state == FS_SPLIT) begin
			{sel_odd3, sel_odd2, sel_odd1} = 3'd0;
			sel_idx1	= src3_hold;
			sel_idx2	= '0;
			sel_idx3	= '0;
			pass_now	= PK_SECOND;
		end else begin
			{sel_odd3, sel_odd2, sel_odd1} = {odd3, odd2, odd1};
			sel_idx1	= src1_idx;
			sel_idx2	= src2_idx;
			sel_idx3	= src3_idx;
			if (!accept)
				pass_now = PK_NONE;
			else if (split)
				pass_now = PK_FIRST;
			else
				pass_now = PK_FULL;
		end
	end

	always_ff @(posedge clk) begin
		if (accept && split)
			src3_hold <= src3_idx;
	end

	////////////////////
	// State and pipeline
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state		<= FS_IDLE;
			route		<= '0;
			pass_kind	<= PK_NONE;
			op_valid	<= 1'b0;
		end else begin
			state		<= (accept && split) ? FS_SPLIT : FS_IDLE;	// One cycle only
			route		<= {sel_odd3, sel_odd2, sel_odd1};
			pass_kind	<= pass_now;
			op_valid	<= (pass_kind == PK_FULL) || (pass_kind == PK_SECOND);
		end
	end

endmodule

//--- src/rf_operand_fetch.sv
`timescale 1ns/100ps

module rf_operand_fetch
	import pkg_rf::*;
(
	input	logic		clk,
	input	logic		arst_n,
	input	logic		issue,
	input	logic		odd1,
	input	logic		odd2,
	input	logic		odd3,
	input	logic		wr_en,
	input	idx_t		src1_idx,
	input	idx_t		src2_idx,
	input	idx_t		src3_idx,
	input	idx_t		wr_idx,
	input	data_t		wr_data,
	output	data_t		op1,
	output	data_t		op2,
	output	data_t		op3,
	output	logic		op_valid,
	output	logic		busy
);

	logic		sel_odd1, sel_odd2, sel_odd3;	// Control to index select
	idx_t		sel_idx1, sel_idx2, sel_idx3;
	route_t		route;							// Control to steering
	logic [1:0]	pass_kind;
	idx_t		port_idx1, port_idx2, port_idx3, port_idx4;
	data_t		port_data1, port_data2, port_data3, port_data4;

	fetch_ctrl i_fetch_ctrl (
		.clk		(clk),
		.arst_n		(arst_n),
		.issue		(issue),
		.odd1		(odd1),
		.odd2		(odd2),
		.odd3		(odd3),
		.src1_idx	(src1_idx),
		.src2_idx	(src2_idx),
		.src3_idx	(src3_idx),
		.sel_odd1	(sel_odd1),
		.sel_odd2	(sel_odd2),
		.sel_odd3	(sel_odd3),
		.sel_idx1	(sel_idx1),
		.sel_idx2	(sel_idx2),
		.sel_idx3	(sel_idx3),
		.route		(route),
		.pass_kind	(pass_kind),
		.busy		(busy),
		.op_valid	(op_valid)
	);

	rf_index_sel i_rf_index_sel (
		.odd1		(sel_odd1),
		.odd2		(sel_odd2),
		.odd3		(sel_odd3),
		.idx_src1	(sel_idx1),
		.idx_src2	(sel_idx2),
		.idx_src3	(sel_idx3),
		.port_idx1	(port_idx1),
		.port_idx2	(port_idx2),
		.port_idx3	(port_idx3),
		.port_idx4	(port_idx4)
	);

	rf_array i_rf_array (
		.clk		(clk),
		.arst_n		(arst_n),
		.wr_en		(wr_en),
		.wr_idx		(wr_idx),
		.wr_data	(wr_data),
		.port_idx1	(port_idx1),
		.port_idx2	(port_idx2),
		.port_idx3	(port_idx3),
		.port_idx4	(port_idx4),
		.port_data1	(port_data1),
		.port_data2	(port_data2),
		.port_data3	(port_data3),
		.port_data4	(port_data4)
	);

	rf_read_steer i_rf_read_steer (
		.clk		(clk),
		.arst_n		(arst_n),
		.pass_kind	(pass_kind),
		.route		(route),
		.port_data1	(port_data1),
		.port_data2	(port_data2),
		.port_data3	(port_data3),
		.port_data4	(port_data4),
		.op1		(op1),
		.op2		(op2),
		.op3		(op3)
	);

endmodule

//--- verification/tb_rf_operand_fetch.sv
`timescale 1ns/100ps

module tb_rf_operand_fetch
	import pkg_rf::*;
();

	localparam int CLK_PERIOD	= 20;
	localparam int NUM_TESTS	= 4 + 24 + 12 + 60 + 2;		// Issues over all phases
	localparam int WATCHDOG_NS	= (NUM_TESTS * 4 + 2 * NUM_REGS + 200) * CLK_PERIOD;

	logic		clk, arst_n, issue, wr_en;
	logic		odd1, odd2, odd3;
	idx_t		src1_idx, src2_idx, src3_idx, wr_idx;
	data_t		wr_data;
	data_t		op1, op2, op3;
	logic		op_valid, busy;

	data_t		model [NUM_REGS];				// Mirror of the array
	data_t		exp1_q[$], exp2_q[$], exp3_q[$];	// Expected operands, issue order
	int			due_q[$];						// Cycle where op_valid is due
	int			cyc;							// Rising edges seen
	int			busy_due;						// Cycle where busy is due
	logic [31:0]	lfsr;

	rf_operand_fetch i_rf_operand_fetch (
		.clk		(clk),
		.arst_n		(arst_n),
		.issue		(issue),
		.odd1		(odd1),
		.odd2		(odd2),
		.odd3		(odd3),
		.wr_en		(wr_en),
		.src1_idx	(src1_idx),
		.src2_idx	(src2_idx),
		.src3_idx	(src3_idx),
		.wr_idx		(wr_idx),
		.wr_data	(wr_data),
		.op1		(op1),
		.op2		(op2),
		.op3		(op3),
		.op_valid	(op_valid),
		.busy		(busy)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////
	// Random bits, Galois LFSR
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);	// One step per bit
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic stop_on_error();
		$display("Finished with errors");
		$fatal(1, "Run stopped at first error");
	endtask

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			$display("** Error %s: got %h, expected %h", name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("** Error %s: got %h, expected %h", name, got, exp);
			stop_on_error();
		end
	endtask

	////////////////////
	// Stimulus, one clock per call
	task automatic drive_cycle(input logic iss, input route_t code, input idx_t s1,
			input idx_t s2, input idx_t s3, input logic we, input idx_t wi, input data_t wd);
		logic split;
		split = (code == 3'd0) || (code == 3'd7);			// No slot for source 3
		issue = iss;
		{odd3, odd2, odd1} = code;
		src1_idx = s1;
		src2_idx = s2;
		src3_idx = s3;
		wr_en = we;
		wr_idx = wi;
		wr_data = wd;
		// Second pass owns the next edge, issue dropped
		if (iss && (busy_due != cyc)) begin
			exp1_q.push_back(model[s1]);
			exp2_q.push_back(model[s2]);
			exp3_q.push_back(model[s3]);
			due_q.push_back(split ? cyc + 3 : cyc + 2);
			if (split)
				busy_due = cyc + 1;
		end
		if (we)
			model[wi] = wd;									// Reads this edge see old word
		@(posedge clk);
		#2;
		issue = 1'b0;
		wr_en = 1'b0;
	endtask

	task automatic issue_random(input route_t code);
		drive_cycle(1'b1, code, idx_t'(rand_bits(IDX_W)), idx_t'(rand_bits(IDX_W)),
			idx_t'(rand_bits(IDX_W)), 1'b0, '0, '0);
	endtask

	task automatic wait_drain();
		while (due_q.size() > 0)
			drive_cycle(1'b0, 3'd0, '0, '0, '0, 1'b0, '0, '0);
	endtask

	// Output check, once per cycle
	task automatic check_outputs();
		logic exp_valid;
		exp_valid = (due_q.size() > 0) && (due_q[0] == cyc);
		check_flag("busy", busy, cyc == busy_due);
		check_flag("op_valid", op_valid, exp_valid);
		if (exp_valid) begin
			check_data("op1", op1, exp1_q.pop_front());
			check_data("op2", op2, exp2_q.pop_front());
			check_data("op3", op3, exp3_q.pop_front());
			void'(due_q.pop_front());
		end
	endtask

	////////////////////
	// Monitor and watchdog
	initial begin
		forever begin
			@(posedge clk);
			#1;												// Outputs settled
			cyc++;
			if (arst_n)
				check_outputs();
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout after %0d ns, op_valid never came for a pending issue", WATCHDOG_NS);
		stop_on_error();
	end

	initial begin
		idx_t r;
		clk = 1'b0;
		arst_n = 1'b0;
		issue = 1'b0;
		{odd3, odd2, odd1} = 3'd0;
		src1_idx = '0;
		src2_idx = '0;
		src3_idx = '0;
		wr_en = 1'b0;
		wr_idx = '0;
		wr_data = '0;
		lfsr = 32'h70d3_8e5a;
		cyc = 0;
		busy_due = -10;
		for (int i = 0; i < NUM_REGS; i++)
			model[i] = '0;
		repeat (2) @(posedge clk);
		#2;
		arst_n = 1'b1;

		// Reset state
		check_flag("op_valid", op_valid, 1'b0);
		check_flag("busy", busy, 1'b0);
		check_data("op1", op1, '0);
		check_data("op2", op2, '0);
		check_data("op3", op3, '0);
		for (int i = 0; i < 4; i++) begin				// Empty array reads zero
			issue_random(route_t'(rand_bits(3)));
			wait_drain();
		end

		// Fill, then every single-pass code
		for (int i = 0; i < NUM_REGS; i++)
			drive_cycle(1'b0, 3'd0, '0, '0, '0, 1'b1, idx_t'(i), rand_bits(DATA_W));
		for (int c = 1; c <= 6; c++) begin
			for (int n = 0; n < 4; n++) begin
				issue_random(route_t'(c));
				wait_drain();
			end
		end

		// Split codes 0 and 7
		for (int n = 0; n < 6; n++) begin
			issue_random(3'd0);
			wait_drain();
			issue_random(3'd7);
			wait_drain();
		end

		// Back to back, issues during busy get dropped
		for (int n = 0; n < 60; n++)
			issue_random(route_t'(rand_bits(3)));
		wait_drain();

		// Write and read on the same edge
		r = idx_t'(rand_bits(IDX_W));
		drive_cycle(1'b1, 3'd3, r, idx_t'(rand_bits(IDX_W)), r, 1'b1, r, rand_bits(DATA_W));
		wait_drain();
		drive_cycle(1'b1, 3'd5, r, r, r, 1'b0, '0, '0);	// New word now
		wait_drain();
		repeat (4)
			drive_cycle(1'b0, 3'd0, '0, '0, '0, 1'b0, '0, '0);

		$display("Finished with no errors");
		$finish;
	end

endmodule

//--- flist.f
common/pkg_rf.sv
src/rf_index_sel.sv
register_file/rf_array.sv
src/rf_read_steer.sv
src/fetch_ctrl.sv
src/rf_operand_fetch.sv
verification/tb_rf_operand_fetch.sv
